// File: byte_fifo.f
+incdir+.
byte_fifo_pkg.sv
memory_dp.sv
ptr_sync.sv
byte_packer.sv
word_reader.sv
byte_fifo_top.sv
tb_byte_fifo.sv

// File: byte_fifo_params.svh
//////////////////////////////////////////////////////////////////////
// byte fifo parameters
// sizes shared by the packer, the reader and the memory
//////////////////////////////////////////////////////////////////////

`ifndef BYTE_FIFO_PARAMS_SVH
`define BYTE_FIFO_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// memory geometry
//////////////////////////////////////////////////////////////////////

// row address bits, 16 rows
`define BF_AW 4

// word width in bits
`define BF_DW 32

`define BF_LANES (`BF_DW / 8) // bytes per word

// number of memory rows
`define BF_DEPTH (1 << `BF_AW)

`endif

// File: byte_fifo_pkg.sv
//////////////////////////////////////////////////////////////////////
// byte fifo package
// width types and the read-side state encoding
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "byte_fifo_params.svh"

package byte_fifo_pkg;

  //////////////////////////////////////////////////////////////////////
  // data path widths
  //////////////////////////////////////////////////////////////////////

  typedef logic [7:0]            byte_t;  // one stream byte
  typedef logic [`BF_DW-1:0]     word_t;  // one memory row
  typedef logic [`BF_AW-1:0]     addr_t;  // row address
  typedef logic [`BF_AW:0]       ptr_t;   // address plus wrap bit
  typedef logic [`BF_LANES-1:0]  lane_t;  // one enable per byte lane

  // word_reader fetch states
  typedef enum logic [1:0] {
    RD_EMPTY = 2'd0,  // nothing to show
    RD_FETCH = 2'd1,  // memory read in flight
    RD_HOLD  = 2'd2   // word on output, waiting for pop
  } rd_state_t;

endpackage

`default_nettype wire

// File: byte_fifo_top.sv
//////////////////////////////////////////////////////////////////////
// dual-clock byte to word packing FIFO, top level
//////////////////////////////////////////////////////////////////////

`default_nettype none

module byte_fifo_top (
  input  wire                   wr_clk,
  input  wire                   rd_clk,
  input  wire                   rst_n,       // covers both clocks
  // write side
  input  byte_fifo_pkg::byte_t  byte_data,
  input  wire                   byte_valid,
  input  wire                   byte_last,
  output logic                  full,
  // read side
  input  wire                   pop,
  output byte_fifo_pkg::word_t  word_data,
  output logic                  word_valid
);

  // memory write port
  byte_fifo_pkg::lane_t  mem_wr_en;
  byte_fifo_pkg::addr_t  mem_wr_addr;
  byte_fifo_pkg::word_t  mem_wr_data;
  // memory read port
  logic                  mem_rd_en;
  byte_fifo_pkg::addr_t  mem_rd_addr;
  byte_fifo_pkg::word_t  mem_rd_data;
  // pointer crossing
  byte_fifo_pkg::ptr_t   wr_gray;      // wr_clk domain
  byte_fifo_pkg::ptr_t   rd_gray;      // rd_clk domain
  byte_fifo_pkg::ptr_t   wr_ptr_sync;  // seen on rd_clk
  byte_fifo_pkg::ptr_t   rd_ptr_sync;  // seen on wr_clk

  byte_packer u_packer (
    .wr_clk      (wr_clk),
    .rst_n       (rst_n),
    .byte_data   (byte_data),
    .byte_valid  (byte_valid),
    .byte_last   (byte_last),
    .rd_ptr_sync (rd_ptr_sync),
    .full        (full),
    .wr_en       (mem_wr_en),
    .wr_addr     (mem_wr_addr),
    .wr_data     (mem_wr_data),
    .wr_gray     (wr_gray)
  );

  memory_dp u_mem (
    .wr_clk  (wr_clk),
    .wr_en   (mem_wr_en),
    .wr_addr (mem_wr_addr),
    .wr_data (mem_wr_data),
    .rd_clk  (rd_clk),
    .rd_en   (mem_rd_en),
    .rd_addr (mem_rd_addr),
    .rd_data (mem_rd_data)
  );

  word_reader u_reader (
    .rd_clk      (rd_clk),
    .rst_n       (rst_n),
    .pop         (pop),
    .wr_ptr_sync (wr_ptr_sync),
    .rd_en       (mem_rd_en),
    .rd_addr     (mem_rd_addr),
    .rd_data     (mem_rd_data),
    .word_data   (word_data),
    .word_valid  (word_valid),
    .rd_gray     (rd_gray)
  );

  // write pointer into the read domain
  ptr_sync u_wr_sync (
    .clk     (rd_clk),
    .rst_n   (rst_n),
    .gray_in (wr_gray),
    .bin_out (wr_ptr_sync)
  );

  // read pointer back into the write domain
  ptr_sync u_rd_sync (
    .clk     (wr_clk),
    .rst_n   (rst_n),
    .gray_in (rd_gray),
    .bin_out (rd_ptr_sync)
  );

endmodule

`default_nettype wire

// File: byte_packer.sv
//////////////////////////////////////////////////////////////////////
// byte packer, write clock domain
// steers bytes into word lanes, zero-fills on last, keeps wr ptr
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "byte_fifo_params.svh"

module byte_packer (
  input  wire                   wr_clk,
  input  wire                   rst_n,
  // byte stream in
  input  byte_fifo_pkg::byte_t  byte_data,
  input  wire                   byte_valid,   // strobe
  input  wire                   byte_last,    // only looked at with byte_valid
  input  byte_fifo_pkg::ptr_t   rd_ptr_sync,  // reader pointer, binary, synced
  output logic                  full,
  // memory write port
  output byte_fifo_pkg::lane_t  wr_en,
  output byte_fifo_pkg::addr_t  wr_addr,
  output byte_fifo_pkg::word_t  wr_data,
  output byte_fifo_pkg::ptr_t   wr_gray       // to the read domain
);

  localparam int LW = $clog2(`BF_LANES);  // lane counter width

  logic [LW-1:0]        lane_q;       // next lane to fill
  byte_fifo_pkg::ptr_t  wr_bin_q;     // row being filled, with wrap bit
  byte_fifo_pkg::ptr_t  wr_bin_next;
  logic                 accept;       // byte taken this cycle
  logic                 close;        // current word finishes

  //////////////////////////////////////////////////////////////////////
  // accept and close
  //////////////////////////////////////////////////////////////////////

  assign accept = byte_valid && !full;  // dropped when full
  assign close  = accept && (byte_last || (lane_q == LW'(`BF_LANES - 1)));

  assign wr_bin_next = close ? wr_bin_q + 1'b1 : wr_bin_q;

  //////////////////////////////////////////////////////////////////////
  // lane enables and data
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    wr_en   = '0;
    wr_data = '0;  // zero in every other lane, used by the fill on last
    for (int i = 0; i < `BF_LANES; i++) begin
      if (i == lane_q) begin
        wr_data[i*8 +: 8] = byte_data;
      end
      // own lane, plus all higher lanes when the word closes early
      if (accept && ((i == lane_q) || (byte_last && (i > lane_q)))) begin
        wr_en[i] = 1'b1;
      end
    end
  end

  assign wr_addr = wr_bin_q[`BF_AW-1:0];  // open row, not yet visible to reader

  //////////////////////////////////////////////////////////////////////
  // lane counter, pointers, full
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge wr_clk) begin
    if (!rst_n) begin
      lane_q   <= '0;
      wr_bin_q <= '0;
      wr_gray  <= '0;
      full     <= 1'b0;
    end else begin
      if (close) begin
        lane_q <= '0;  // next byte starts a new word
      end else if (accept) begin
        lane_q <= lane_q + 1'b1;
      end
      wr_bin_q <= wr_bin_next;
      wr_gray  <= wr_bin_next ^ (wr_bin_next >> 1);  // binary to gray
      // full once all rows hold unread words, wrap bit differs
      full <= (wr_bin_next == {~rd_ptr_sync[`BF_AW], rd_ptr_sync[`BF_AW-1:0]});
    end
  end

endmodule

`default_nettype wire

// File: memory_dp.sv
//////////////////////////////////////////////////////////////////////
// dual-port memory, one write port with byte lanes
// and one registered read port, each on its own clock
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "byte_fifo_params.svh"

module memory_dp (
  // write port
  input  wire                   wr_clk,
  input  byte_fifo_pkg::lane_t  wr_en,    // one bit per byte lane
  input  byte_fifo_pkg::addr_t  wr_addr,
  input  byte_fifo_pkg::word_t  wr_data,
  // read port
  input  wire                   rd_clk,
  input  wire                   rd_en,
  input  byte_fifo_pkg::addr_t  rd_addr,
  output byte_fifo_pkg::word_t  rd_data
);

  // storage array
  byte_fifo_pkg::word_t ram [`BF_DEPTH];

  //////////////////////////////////////////////////////////////////////
  // write port
  //////////////////////////////////////////////////////////////////////

  // each enabled lane updates its own byte of the row
  always_ff @(posedge wr_clk) begin
    for (int i = 0; i < `BF_LANES; i++) begin
      if (wr_en[i]) begin
        ram[wr_addr][i*8 +: 8] <= wr_data[i*8 +: 8];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read port
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge rd_clk) begin
    if (rd_en) begin
      rd_data <= ram[rd_addr];  // held while rd_en is low
    end
  end

endmodule

`default_nettype wire

// File: ptr_sync.sv
//////////////////////////////////////////////////////////////////////
// gray pointer synchronizer
// two flops on the destination clock, then back to binary
//////////////////////////////////////////////////////////////////////

`default_nettype none

module ptr_sync (
  input  wire                  clk,      // destination clock
  input  wire                  rst_n,
  input  byte_fifo_pkg::ptr_t  gray_in,  // from the other domain
  output byte_fifo_pkg::ptr_t  bin_out
);

  byte_fifo_pkg::ptr_t sync1_q;  // may go metastable
  byte_fifo_pkg::ptr_t sync2_q;  // settled copy

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sync1_q <= '0;
      sync2_q <= '0;
    end else begin
      sync1_q <= gray_in;
      sync2_q <= sync1_q;
    end
  end

  // gray to binary, each bit is the xor of all gray bits above it
  always_comb begin
    for (int i = 0; i < $bits(sync2_q); i++) begin
      bin_out[i] = ^(sync2_q >> i);
    end
  end

endmodule

`default_nettype wire

// File: tb_byte_fifo.sv
//////////////////////////////////////////////////////////////////////
// testbench for the dual-clock byte packing FIFO
// table of bytes in, packed words out, two unrelated clocks
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "byte_fifo_params.svh"

module tb_byte_fifo;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NW       = 24;                      // words in the table
  localparam int MAX_B    = NW * `BF_LANES;          // byte table size
  localparam int LIMIT_NS = NW * 4 * 14 * 8 + 2000;  // margin for the fill phase

  logic                  wr_clk;
  logic                  rd_clk;
  logic                  rst_n;
  byte_fifo_pkg::byte_t  byte_data;
  logic                  byte_valid;
  logic                  byte_last;
  logic                  full;
  logic                  pop;
  byte_fifo_pkg::word_t  word_data;
  logic                  word_valid;

  //////////////////////////////////////////////////////////////////////
  // stimulus and expected tables
  //////////////////////////////////////////////////////////////////////

  int                    word_lens [NW];     // bytes per word where under 4 closes early
  byte_fifo_pkg::byte_t  byte_tab  [MAX_B];
  logic                  last_tab  [MAX_B];
  byte_fifo_pkg::word_t  exp_words [NW];     // packed by the lane rule
  int                    n_bytes;

  logic [31:0]           rng_state;          // xorshift state
  logic                  saw_full;           // writer was held off at least once
  logic                  writer_done;

  byte_fifo_top dut (
    .wr_clk     (wr_clk),
    .rd_clk     (rd_clk),
    .rst_n      (rst_n),
    .byte_data  (byte_data),
    .byte_valid (byte_valid),
    .byte_last  (byte_last),
    .full       (full),
    .pop        (pop),
    .word_data  (word_data),
    .word_valid (word_valid)
  );

  always #5 rd_clk = ~rd_clk;  // 10 ns
  always #7 wr_clk = ~wr_clk;  // 14 ns and unrelated to rd_clk

  function automatic logic [31:0] next_random();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // byte table first, then the words it must pack into
  task automatic build_tables();
    int                    lane;
    int                    w;
    byte_fifo_pkg::word_t  acc;
    // full words, early closes at every lane, then enough to overrun 16 rows
    word_lens = '{4, 4, 4, 1, 4, 2, 4, 3, 4, 1, 1, 2,
                  3, 4, 4, 4, 2, 4, 4, 1, 4, 3, 4, 4};
    n_bytes = 0;
    for (int i = 0; i < NW; i++) begin
      for (int k = 0; k < word_lens[i]; k++) begin
        byte_tab[n_bytes] = 8'(n_bytes * 7 + 8'h31);  // all distinct below 256
        last_tab[n_bytes] = (k == word_lens[i] - 1) && (word_lens[i] < `BF_LANES);
        n_bytes++;
      end
    end
    lane = 0;
    w    = 0;
    acc  = '0;
    for (int i = 0; i < n_bytes; i++) begin
      acc[lane*8 +: 8] = byte_tab[i];  // first byte in the lowest lane
      if (last_tab[i] || (lane == `BF_LANES - 1)) begin
        exp_words[w] = acc;            // lanes above stay zero
        w++;
        acc  = '0;
        lane = 0;
      end else begin
        lane++;
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // checks
  //////////////////////////////////////////////////////////////////////

  task automatic expect_word(input string name, input byte_fifo_pkg::word_t exp,
                             input byte_fifo_pkg::word_t act);
    if (act !== exp) begin
      $display("ERR %s expected %08h actual %08h", name, exp, act);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  task automatic verify_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("ERR %s expected %b actual %b", name, exp, act);
      $display("test failed");
      $fatal(1, "stopped at the first mismatch");
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // writer and reader
  //////////////////////////////////////////////////////////////////////

  task automatic run_writer();
    for (int i = 0; i < n_bytes; i++) begin
      @(negedge wr_clk);
      while (full) begin
        byte_valid = 1'b0;  // a byte offered now would be dropped
        saw_full   = 1'b1;
        @(negedge wr_clk);
      end
      byte_data  = byte_tab[i];
      byte_last  = last_tab[i];
      byte_valid = 1'b1;
    end
    @(negedge wr_clk);
    byte_valid  = 1'b0;
    byte_last   = 1'b0;
    writer_done = 1'b1;
  endtask

  task automatic run_reader();
    logic                  seen;
    int                    gap;
    seen = 1'b0;
    // no pops until the writer is pushed back
    while (!saw_full && !writer_done) begin
      @(negedge rd_clk);
      if (seen) begin
        verify_flag("valid while stalled", 1'b1, word_valid);
        expect_word("data while stalled", exp_words[0], word_data);  // still the first word
      end else if (word_valid) begin
        expect_word("first word shown", exp_words[0], word_data);
        seen = 1'b1;
      end
    end
    verify_flag("full under back-pressure", 1'b1, saw_full);
    verify_flag("valid under back-pressure", 1'b1, word_valid);
    // every word in order and each compared once
    for (int w = 0; w < NW; w++) begin
      while (!word_valid) begin
        @(negedge rd_clk);
      end
      expect_word($sformatf("word %0d", w), exp_words[w], word_data);
      pop = 1'b1;
      @(negedge rd_clk);
      pop = 1'b0;
      gap = int'(next_random() % 4);  // 0 to 3 idle cycles
      repeat (gap) @(negedge rd_clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    wr_clk      = 1'b0;
    rd_clk      = 1'b0;
    rst_n       = 1'b0;
    byte_data   = '0;
    byte_valid  = 1'b0;
    byte_last   = 1'b0;
    pop         = 1'b0;
    saw_full    = 1'b0;
    writer_done = 1'b0;
    rng_state   = 32'd55;
    build_tables();
    repeat (2) @(posedge rd_clk);  // also spans a wr_clk edge
    @(negedge rd_clk);
    rst_n = 1'b1;
    // nothing offered yet
    verify_flag("valid after reset", 1'b0, word_valid);
    verify_flag("full after reset", 1'b0, full);
    fork
      run_writer();
      run_reader();
    join
    // drained so nothing more may show up
    repeat (20) begin
      @(negedge rd_clk);
      verify_flag("valid after drain", 1'b0, word_valid);
    end
    verify_flag("full after drain", 1'b0, full);
    $display("test passed");
    $finish;
  end

  // watchdog
  initial begin
    #(LIMIT_NS);
    $display("timeout, not every word came out within %0d ns", LIMIT_NS);
    $display("test failed");
    $fatal(1, "watchdog expired");
  end

endmodule

`default_nettype wire

// File: word_reader.sv
//////////////////////////////////////////////////////////////////////
// word reader, read clock domain
// fetches the word at the read pointer and holds it until popped
//////////////////////////////////////////////////////////////////////

`default_nettype none

`include "byte_fifo_params.svh"

module word_reader (
  input  wire                   rd_clk,
  input  wire                   rst_n,
  input  wire                   pop,          // strobe, ignored without word_valid
  input  byte_fifo_pkg::ptr_t   wr_ptr_sync,  // writer pointer, binary, synced
  // memory read port
  output logic                  rd_en,
  output byte_fifo_pkg::addr_t  rd_addr,
  input  byte_fifo_pkg::word_t  rd_data,
  // word out
  output byte_fifo_pkg::word_t  word_data,
  output logic                  word_valid,
  output byte_fifo_pkg::ptr_t   rd_gray       // to the write domain
);

  byte_fifo_pkg::rd_state_t  state_q;
  byte_fifo_pkg::rd_state_t  state_d;
  byte_fifo_pkg::ptr_t       rd_bin_q;     // word on output, or next to fetch
  byte_fifo_pkg::ptr_t       rd_bin_next;
  logic                      take;         // word consumed this cycle

  assign take        = pop && (state_q == byte_fifo_pkg::RD_HOLD);
  assign rd_bin_next = rd_bin_q + 1'b1;

  //////////////////////////////////////////////////////////////////////
  // fetch state machine
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d = state_q;
    rd_en   = 1'b0;
    rd_addr = rd_bin_q[`BF_AW-1:0];
    case (state_q)
      byte_fifo_pkg::RD_EMPTY: begin
        if (wr_ptr_sync != rd_bin_q) begin  // a closed word is waiting
          rd_en   = 1'b1;
          state_d = byte_fifo_pkg::RD_FETCH;
        end
      end
      byte_fifo_pkg::RD_FETCH: begin
        state_d = byte_fifo_pkg::RD_HOLD;  // rd_data valid now
      end
      byte_fifo_pkg::RD_HOLD: begin
        if (take) begin
          if (wr_ptr_sync != rd_bin_next) begin
            // refetch straight away, valid drops one cycle
            rd_en   = 1'b1;
            rd_addr = rd_bin_next[`BF_AW-1:0];
            state_d = byte_fifo_pkg::RD_FETCH;
          end else begin
            state_d = byte_fifo_pkg::RD_EMPTY;
          end
        end
      end
      default: state_d = byte_fifo_pkg::RD_EMPTY;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // state and pointers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge rd_clk) begin
    if (!rst_n) begin
      state_q  <= byte_fifo_pkg::RD_EMPTY;
      rd_bin_q <= '0;
      rd_gray  <= '0;
    end else begin
      state_q <= state_d;
      if (take) begin
        rd_bin_q <= rd_bin_next;
        rd_gray  <= rd_bin_next ^ (rd_bin_next >> 1);  // frees the row to the writer
      end
    end
  end

  // output word register, loaded at the end of a fetch
  always_ff @(posedge rd_clk) begin
    if (state_q == byte_fifo_pkg::RD_FETCH) begin
      word_data <= rd_data;
    end
  end

  assign word_valid = (state_q == byte_fifo_pkg::RD_HOLD);  // steady until pop

endmodule

`default_nettype wire
